// File: common/trap_macros.svh
`ifndef TRAP_MACROS_SVH
`define TRAP_MACROS_SVH

// Data path width
`define XLEN 64

// ----------------------------------------------------------
// Machine-mode CSR addresses
// ----------------------------------------------------------
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MIP     12'h344

// mcause codes, interrupt flag in the top bit
`define CAUSE_ECALL_M   {{(`XLEN-4){1'b0}}, 4'd11}
`define CAUSE_TIMER_IRQ {1'b1, {(`XLEN-4){1'b0}}, 3'd7}

`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MTIE_BIT         7  // Same position in mie and mip

`define MTVEC_RESET {{(`XLEN-32){1'b0}}, 32'h8000_0100}

`endif

// File: common/trap_pkg.sv
`default_nettype none
`include "trap_macros.svh"

package trap_pkg;

	// One instruction leaving write-back
	typedef struct packed {
		logic             valid;
		logic [31:0]      instr;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1_data;  // Already forwarded
	} retire_t;

	typedef enum logic [1:0] {
		SYS_NONE,
		SYS_CSR,
		SYS_ECALL,
		SYS_MRET
	} sys_class_e;

	typedef struct packed {
		logic             wr_en;
		logic [11:0]      addr;
		logic [`XLEN-1:0] wdata;
	} csr_req_t;

	// Trap entry or return for this cycle
	typedef struct packed {
		logic             enter;
		logic             ret;
		logic [`XLEN-1:0] cause;
		logic [`XLEN-1:0] epc;
	} trap_evt_t;

	typedef struct packed {
		logic             mstatus_mie;
		logic             mie_mtie;
		logic [`XLEN-1:0] mtvec;
		logic [`XLEN-1:0] mepc;
	} csr_view_t;

	typedef struct packed {
		logic             valid;
		logic [4:0]       rd;
		logic [`XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
	} redirect_t;

endpackage

`default_nettype wire

// File: csr/csr_file.sv
`default_nettype none
`include "trap_macros.svh"

module csr_file (
	input  wire                     clk,
	input  wire                     sft_rst,
	input  wire [11:0]              i_csr_addr,
	input  wire trap_pkg::csr_req_t  i_csr_req,
	input  wire trap_pkg::trap_evt_t i_trap,
	input  wire                     i_clint_timer_irq,
	output logic [`XLEN-1:0]        o_csr_rdata,
	output trap_pkg::csr_view_t     o_view
);
	import trap_pkg::*;

	// Only the implemented fields are stored
	logic             mstatus_mie;
	logic             mstatus_mpie;
	logic             mie_mtie;
	logic [`XLEN-1:0] mtvec;
	logic [`XLEN-1:0] mepc;
	logic [`XLEN-1:0] mcause;

	// ----------------------------------------------------------
	// Read port
	// ----------------------------------------------------------
	always_comb begin
		o_csr_rdata = '0;  // Unimplemented CSRs read zero
		case (i_csr_addr)
			`CSR_MSTATUS: begin
				o_csr_rdata[`MSTATUS_MIE_BIT]  = mstatus_mie;
				o_csr_rdata[`MSTATUS_MPIE_BIT] = mstatus_mpie;
			end
			`CSR_MIE: o_csr_rdata[`MTIE_BIT] = mie_mtie;
			`CSR_MIP: o_csr_rdata[`MTIE_BIT] = i_clint_timer_irq;  // Live MTIP
			`CSR_MTVEC:  o_csr_rdata = mtvec;
			`CSR_MEPC:   o_csr_rdata = mepc;
			`CSR_MCAUSE: o_csr_rdata = mcause;
			default: ;
		endcase
	end

	// ----------------------------------------------------------
	// Updates, trap actions ahead of instruction writes
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sft_rst) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_mtie     <= 1'b0;
			mtvec        <= `MTVEC_RESET;
			mepc         <= '0;
			mcause       <= '0;
		end else if (i_trap.enter) begin
			mstatus_mpie <= mstatus_mie;
			mstatus_mie  <= 1'b0;   // Interrupts off in the handler
			mepc         <= i_trap.epc;
			mcause       <= i_trap.cause;
		end else if (i_trap.ret) begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end else if (i_csr_req.wr_en) begin
			case (i_csr_req.addr)
				`CSR_MSTATUS: begin
					mstatus_mie  <= i_csr_req.wdata[`MSTATUS_MIE_BIT];
					mstatus_mpie <= i_csr_req.wdata[`MSTATUS_MPIE_BIT];
				end
				`CSR_MIE:    mie_mtie <= i_csr_req.wdata[`MTIE_BIT];
				`CSR_MTVEC:  mtvec    <= i_csr_req.wdata;
				`CSR_MEPC:   mepc     <= i_csr_req.wdata;
				`CSR_MCAUSE: mcause   <= i_csr_req.wdata;
				default: ;  // mip and unknown addresses
			endcase
		end
	end

	// Fields the trap controller decides on
	assign o_view.mstatus_mie = mstatus_mie;
	assign o_view.mie_mtie    = mie_mtie;
	assign o_view.mtvec       = mtvec;
	assign o_view.mepc        = mepc;

endmodule

`default_nettype wire

// File: src/sys_decode.sv
`default_nettype none
`include "trap_macros.svh"

module sys_decode (
	input  wire                    clk,
	input  wire                    sft_rst,
	input  wire trap_pkg::retire_t  i_retire,
	input  wire                    i_irq_take,   // Interrupt cancels this retire
	input  wire [`XLEN-1:0]        i_csr_rdata,
	output logic [11:0]            o_csr_addr,
	output trap_pkg::sys_class_e   o_class,
	output trap_pkg::csr_req_t     o_csr_req,
	output trap_pkg::wb_t          o_wb
);
	import trap_pkg::*;

	localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
	localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
	localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;

	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic [4:0]       rd;
	logic [4:0]       rs1_field;  // rs1 index or uimm
	logic [`XLEN-1:0] src;
	logic             is_csr;

	assign opcode     = i_retire.instr[6:0];
	assign funct3     = i_retire.instr[14:12];
	assign rd         = i_retire.instr[11:7];
	assign rs1_field  = i_retire.instr[19:15];
	assign o_csr_addr = i_retire.instr[31:20];

	// ----------------------------------------------------------
	// Classify the retiring instruction
	// ----------------------------------------------------------
	always_comb begin
		o_class = SYS_NONE;
		if (i_retire.valid && opcode == OPC_SYSTEM) begin
			if (funct3 != 3'b000) begin
				o_class = SYS_CSR;
			end else if (i_retire.instr == INSTR_ECALL) begin
				o_class = SYS_ECALL;
			end else if (i_retire.instr == INSTR_MRET) begin
				o_class = SYS_MRET;
			end
		end
	end

	assign is_csr = (o_class == SYS_CSR);

	// Immediate forms take the zero-extended uimm
	assign src = funct3[2] ? {{(`XLEN-5){1'b0}}, rs1_field} : i_retire.rs1_data;

	// Read-modify-write value
	always_comb begin
		o_csr_req.addr = o_csr_addr;
		case (funct3[1:0])
			2'b01:   o_csr_req.wdata = src;                // Write
			2'b10:   o_csr_req.wdata = i_csr_rdata | src;  // Set
			2'b11:   o_csr_req.wdata = i_csr_rdata & ~src; // Clear
			default: o_csr_req.wdata = i_csr_rdata;
		endcase
		// Set and clear with a zero source leave the CSR alone
		o_csr_req.wr_en = is_csr && !i_irq_take && funct3[1:0] != 2'b00 &&
			(funct3[1:0] == 2'b01 || rs1_field != 5'd0);
	end

	// ----------------------------------------------------------
	// Destination write-back, old CSR value
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		o_wb.rd   <= rd;
		o_wb.data <= i_csr_rdata;
		if (sft_rst) begin
			o_wb.valid <= 1'b0;
		end else begin
			o_wb.valid <= is_csr && rd != 5'd0 && !i_irq_take;
		end
	end

endmodule

`default_nettype wire

// File: src/trap_ctrl.sv
`default_nettype none
`include "trap_macros.svh"

module trap_ctrl (
	input  wire                     clk,
	input  wire                     sft_rst,
	input  wire trap_pkg::retire_t   i_retire,
	input  wire trap_pkg::sys_class_e i_class,
	input  wire                     i_clint_timer_irq,
	input  wire trap_pkg::csr_view_t i_view,
	output logic                    o_irq_take,
	output trap_pkg::trap_evt_t     o_trap,
	output trap_pkg::redirect_t     o_redirect,
	output logic                    o_timer_irq_ready  // Pulse with the redirect
);
	import trap_pkg::*;

	logic ecall_take;
	logic mret_take;

	// ----------------------------------------------------------
	// Trap decision, interrupt first
	// ----------------------------------------------------------
	assign o_irq_take = i_retire.valid && i_clint_timer_irq &&
		i_view.mstatus_mie && i_view.mie_mtie;

	assign ecall_take = !o_irq_take && (i_class == SYS_ECALL);
	assign mret_take  = !o_irq_take && (i_class == SYS_MRET);

	always_comb begin
		o_trap.enter = o_irq_take || ecall_take;
		o_trap.ret   = mret_take;
		o_trap.cause = o_irq_take ? `CAUSE_TIMER_IRQ : `CAUSE_ECALL_M;
		o_trap.epc   = i_retire.pc;  // Interrupted instruction reruns
	end

	// ----------------------------------------------------------
	// Registered redirect and interrupt acknowledge
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (mret_take) begin
			o_redirect.pc <= i_view.mepc;
		end else begin
			o_redirect.pc <= {i_view.mtvec[`XLEN-1:2], 2'b00};  // Direct mode only
		end
		if (sft_rst) begin
			o_redirect.valid  <= 1'b0;
			o_timer_irq_ready <= 1'b0;
		end else begin
			o_redirect.valid  <= o_trap.enter || o_trap.ret;
			o_timer_irq_ready <= o_irq_take;
		end
	end

endmodule

`default_nettype wire

// File: src/csr_trap_top.sv
`default_nettype none
`include "trap_macros.svh"

module csr_trap_top (
	input  wire                   clk,
	input  wire                   sft_rst,            // Synchronous, active high
	input  wire trap_pkg::retire_t i_retire,
	input  wire                   i_clint_timer_irq,  // Level from the CLINT
	output trap_pkg::wb_t         o_wb,
	output trap_pkg::redirect_t   o_redirect,
	output logic                  o_timer_irq_ready
);
	import trap_pkg::*;

	logic [11:0]      csr_addr;
	logic [`XLEN-1:0] csr_rdata;
	sys_class_e       sys_class;
	csr_req_t         csr_req;
	trap_evt_t        trap;
	csr_view_t        view;
	logic             irq_take;

	sys_decode u_sys_decode (
		.clk         (clk),
		.sft_rst     (sft_rst),
		.i_retire    (i_retire),
		.i_irq_take  (irq_take),
		.i_csr_rdata (csr_rdata),
		.o_csr_addr  (csr_addr),
		.o_class     (sys_class),
		.o_csr_req   (csr_req),
		.o_wb        (o_wb)
	);

	trap_ctrl u_trap_ctrl (
		.clk               (clk),
		.sft_rst           (sft_rst),
		.i_retire          (i_retire),
		.i_class           (sys_class),
		.i_clint_timer_irq (i_clint_timer_irq),
		.i_view            (view),
		.o_irq_take        (irq_take),
		.o_trap            (trap),
		.o_redirect        (o_redirect),
		.o_timer_irq_ready (o_timer_irq_ready)
	);

	csr_file u_csr_file (
		.clk               (clk),
		.sft_rst           (sft_rst),
		.i_csr_addr        (csr_addr),
		.i_csr_req         (csr_req),
		.i_trap            (trap),
		.i_clint_timer_irq (i_clint_timer_irq),
		.o_csr_rdata       (csr_rdata),
		.o_view            (view)
	);

endmodule

`default_nettype wire

// File: testbench/csr_trap_properties.sv
`default_nettype none

module csr_trap_properties (
	input wire                      clk,
	input wire                      sft_rst,
	input wire trap_pkg::retire_t   i_retire,
	input wire trap_pkg::wb_t       i_wb,
	input wire trap_pkg::redirect_t i_redirect,
	input wire                      i_timer_irq_ready
);
	int prop_fails = 0;  // Assertion failures so far

	// Redirect only ever follows a retire strobe
	a_redirect_after_retire: assert property (@(posedge clk) disable iff (sft_rst)
		i_redirect.valid |-> $past(i_retire.valid)) else begin
		$error("redirect valid without a retire one cycle before");
		prop_fails++;
	end

	// Interrupted instruction must not write rd
	a_no_wb_on_irq: assert property (@(posedge clk) disable iff (sft_rst)
		!(i_wb.valid && i_timer_irq_ready)) else begin
		$error("write-back together with an interrupt redirect");
		prop_fails++;
	end

	a_irq_ready_redirect: assert property (@(posedge clk) disable iff (sft_rst)
		i_timer_irq_ready |-> i_redirect.valid) else begin
		$error("interrupt acknowledge without a redirect");
		prop_fails++;
	end

	a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (sft_rst)
		i_wb.valid |-> i_wb.rd != 5'd0) else begin
		$error("write-back to x0");
		prop_fails++;
	end

endmodule

bind csr_trap_top csr_trap_properties u_props (
	.clk               (clk),
	.sft_rst           (sft_rst),
	.i_retire          (i_retire),
	.i_wb              (o_wb),
	.i_redirect        (o_redirect),
	.i_timer_irq_ready (o_timer_irq_ready)
);

`default_nettype wire

// File: testbench/tb_csr_trap.sv
`default_nettype none
`include "trap_macros.svh"

module tb_csr_trap;
	import trap_pkg::*;

	localparam int          MAX_CYCLES  = 400;
	localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
	localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;
	localparam logic [2:0]  F_RW  = 3'b001;
	localparam logic [2:0]  F_RS  = 3'b010;
	localparam logic [2:0]  F_RC  = 3'b011;
	localparam logic [2:0]  F_RWI = 3'b101;
	localparam logic [2:0]  F_RSI = 3'b110;
	localparam logic [2:0]  F_RCI = 3'b111;

	logic      clk;
	logic      sft_rst;
	retire_t   retire;
	logic      timer_irq;
	wb_t       wb;
	redirect_t redirect;
	logic      irq_ready;

	int seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Reference CSR state
	logic             m_mie;
	logic             m_mpie;
	logic             m_mtie;
	logic [`XLEN-1:0] m_mtvec;
	logic [`XLEN-1:0] m_mepc;
	logic [`XLEN-1:0] m_mcause;

	csr_trap_top i_csr_trap_top (
		.clk               (clk),
		.sft_rst           (sft_rst),
		.i_retire          (retire),
		.i_clint_timer_irq (timer_irq),
		.o_wb              (wb),
		.o_redirect        (redirect),
		.o_timer_irq_ready (irq_ready)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, stimulus still running after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] csr_instr(input logic [2:0] funct3,
		input logic [11:0] addr, input logic [4:0] rd, input logic [4:0] rs1f);
		return {addr, rs1f, funct3, rd, 7'b1110011};
	endfunction

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	function automatic logic [`XLEN-1:0] model_read(input logic [11:0] addr);
		logic [`XLEN-1:0] value;
		value = '0;
		case (addr)
			`CSR_MSTATUS: begin
				value[`MSTATUS_MIE_BIT]  = m_mie;
				value[`MSTATUS_MPIE_BIT] = m_mpie;
			end
			`CSR_MIE:    value[`MTIE_BIT] = m_mtie;
			`CSR_MIP:    value[`MTIE_BIT] = timer_irq;  // Pending bit follows the line
			`CSR_MTVEC:  value = m_mtvec;
			`CSR_MEPC:   value = m_mepc;
			`CSR_MCAUSE: value = m_mcause;
			default:     value = '0;
		endcase
		return value;
	endfunction

	function automatic void model_write(input logic [11:0] addr, input logic [`XLEN-1:0] value);
		case (addr)
			`CSR_MSTATUS: begin
				m_mie  = value[`MSTATUS_MIE_BIT];
				m_mpie = value[`MSTATUS_MPIE_BIT];
			end
			`CSR_MIE:    m_mtie   = value[`MTIE_BIT];
			`CSR_MTVEC:  m_mtvec  = value;
			`CSR_MEPC:   m_mepc   = value;
			`CSR_MCAUSE: m_mcause = value;
			default: ;  // Read-only or unknown
		endcase
	endfunction

	function automatic void trap_entry(input logic [`XLEN-1:0] cause, input logic [`XLEN-1:0] epc);
		m_mpie   = m_mie;
		m_mie    = 1'b0;
		m_mepc   = epc;
		m_mcause = cause;
	endfunction

	task automatic check_value(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------------------------
	// One retire at a random pc, checked one cycle later
	// ----------------------------------------------------------
	task automatic retire_check(input logic [31:0] instr, input logic [`XLEN-1:0] rs1);
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] old_val;
		logic [`XLEN-1:0] src;
		logic [`XLEN-1:0] new_val;
		logic [`XLEN-1:0] exp_pc;
		logic [2:0]       funct3;
		logic [4:0]       rd;
		logic [4:0]       rs1f;
		logic             irq;
		logic             exp_wb;
		logic             exp_redir;

		pc        = {$random(seed), $random(seed)};
		funct3    = instr[14:12];
		rd        = instr[11:7];
		rs1f      = instr[19:15];
		irq       = timer_irq && m_mie && m_mtie;
		exp_wb    = 1'b0;
		exp_redir = 1'b0;
		exp_pc    = '0;
		old_val   = model_read(instr[31:20]);
		if (irq) begin  // Interrupt wins over the instruction itself
			exp_redir = 1'b1;
			exp_pc    = {m_mtvec[`XLEN-1:2], 2'b00};
			trap_entry(`CAUSE_TIMER_IRQ, pc);
		end else if (instr[6:0] == 7'b1110011 && funct3 != 3'b000) begin
			src = funct3[2] ? {{(`XLEN-5){1'b0}}, rs1f} : rs1;
			case (funct3[1:0])
				2'b01:   new_val = src;
				2'b10:   new_val = old_val | src;
				default: new_val = old_val & ~src;
			endcase
			exp_wb = (rd != 5'd0);
			if (funct3[1:0] == 2'b01 || rs1f != 5'd0) begin
				model_write(instr[31:20], new_val);
			end
		end else if (instr == INSTR_ECALL) begin
			exp_redir = 1'b1;
			exp_pc    = {m_mtvec[`XLEN-1:2], 2'b00};
			trap_entry(`CAUSE_ECALL_M, pc);
		end else if (instr == INSTR_MRET) begin
			exp_redir = 1'b1;
			exp_pc    = m_mepc;
			m_mie     = m_mpie;
			m_mpie    = 1'b1;
		end

		retire.valid    = 1'b1;
		retire.instr    = instr;
		retire.pc       = pc;
		retire.rs1_data = rs1;
		@(negedge clk);
		retire.valid = 1'b0;

		check_value("o_wb.valid", 64'(wb.valid), 64'(exp_wb));
		if (exp_wb) begin
			check_value("o_wb.rd", 64'(wb.rd), 64'(rd));
			check_value("o_wb.data", wb.data, old_val);
		end
		check_value("o_redirect.valid", 64'(redirect.valid), 64'(exp_redir));
		if (exp_redir) begin
			check_value("o_redirect.pc", redirect.pc, exp_pc);
		end
		check_value("o_timer_irq_ready", 64'(irq_ready), 64'(irq));
	endtask

	initial begin
		clk       = 1'b0;
		sft_rst   = 1'b1;
		retire    = '0;
		timer_irq = 1'b0;
		seed      = 32'hd6ba1acb;
		m_mie     = 1'b0;
		m_mpie    = 1'b0;
		m_mtie    = 1'b0;
		m_mtvec   = `MTVEC_RESET;
		m_mepc    = '0;
		m_mcause  = '0;
		repeat (16) @(negedge clk);
		sft_rst = 1'b0;

		// Writes then reads back, rd zero gives no write-back
		retire_check(csr_instr(F_RW, `CSR_MTVEC, 5'd1, 5'd2), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RW, `CSR_MEPC, 5'd0, 5'd2), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RW, `CSR_MIE, 5'd3, 5'd2), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RS, `CSR_MTVEC, 5'd5, 5'd0), '1);
		retire_check(csr_instr(F_RS, `CSR_MEPC, 5'd5, 5'd0), '1);
		retire_check(csr_instr(F_RS, `CSR_MIE, 5'd5, 5'd0), '1);

		// Set, clear and immediate forms
		retire_check(csr_instr(F_RS, `CSR_MSTATUS, 5'd6, 5'd3), 64'h88);
		retire_check(csr_instr(F_RC, `CSR_MSTATUS, 5'd6, 5'd3), 64'h08);
		retire_check(csr_instr(F_RWI, `CSR_MCAUSE, 5'd7, 5'h15), '0);
		retire_check(csr_instr(F_RSI, `CSR_MCAUSE, 5'd7, 5'h0a), '0);
		retire_check(csr_instr(F_RCI, `CSR_MCAUSE, 5'd7, 5'h03), '0);
		retire_check(csr_instr(F_RCI, `CSR_MSTATUS, 5'd8, 5'h1f), '0);
		retire_check(csr_instr(F_RC, `CSR_MIE, 5'd11, 5'd4), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RS, `CSR_MIE, 5'd11, 5'd0), '0);
		retire_check(csr_instr(F_RW, 12'h7c0, 5'd10, 5'd4), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RS, 12'h7c0, 5'd10, 5'd0), '0);
		retire_check(32'h0010_0093, '1);  // addi, not for this block

		// ecall then mret, MIE set and MPIE clear before the trap
		retire_check(csr_instr(F_RWI, `CSR_MSTATUS, 5'd0, 5'h08), '0);
		retire_check(INSTR_ECALL, '0);
		retire_check(csr_instr(F_RS, `CSR_MEPC, 5'd12, 5'd0), '0);
		retire_check(csr_instr(F_RS, `CSR_MCAUSE, 5'd12, 5'd0), '0);
		retire_check(csr_instr(F_RS, `CSR_MSTATUS, 5'd12, 5'd0), '0);
		retire_check(INSTR_MRET, '0);
		retire_check(csr_instr(F_RS, `CSR_MSTATUS, 5'd13, 5'd0), '0);

		// Timer interrupt, taken once, then masked by the cleared MIE
		retire_check(csr_instr(F_RS, `CSR_MIE, 5'd0, 5'd4), 64'h80);
		timer_irq = 1'b1;
		retire_check(csr_instr(F_RW, `CSR_MEPC, 5'd3, 5'd1), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RW, `CSR_MEPC, 5'd3, 5'd1), {$random(seed), $random(seed)});
		retire_check(csr_instr(F_RS, `CSR_MCAUSE, 5'd4, 5'd0), '0);
		retire_check(csr_instr(F_RS, `CSR_MIP, 5'd4, 5'd0), '0);
		retire_check(csr_instr(F_RS, `CSR_MSTATUS, 5'd4, 5'd0), '0);
		timer_irq = 1'b0;
		retire_check(csr_instr(F_RS, `CSR_MIP, 5'd4, 5'd0), '0);
		@(negedge clk);

		$display("Checks: %0d, failed checks: %0d, property failures: %0d",
			checks, errors, i_csr_trap_top.u_props.prop_fails);
		if (errors == 0 && i_csr_trap_top.u_props.prop_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/trap_pkg.sv
csr/csr_file.sv
src/sys_decode.sv
src/trap_ctrl.sv
src/csr_trap_top.sv
testbench/csr_trap_properties.sv
testbench/tb_csr_trap.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR and trap testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_csr_trap -o tb_csr_trap
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_csr_trap +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
